//--- source/core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

    // physical register file
    localparam int PRF_COUNT = 64;
    localparam int PRF_NUM_W = 6;

    // alu issue queue
    localparam int IQ_DEPTH = 8;
    localparam int IQ_IDX_W = 3;
    // occupancy counter holds 0 .. IQ_DEPTH
    localparam int IQ_CNT_W = 4;

    // port counts
    localparam int DISPATCH_WIDTH = 2;
    localparam int ISSUE_WIDTH = 2;
    localparam int WB_PORTS = 2;

    // scoreboard clear ports, issue wakeups first
    localparam int CLEAR_PORTS = ISSUE_WIDTH + WB_PORTS;

    localparam int TAG_W = 8;

endpackage

`default_nettype wire

//--- source/issue_pkg.sv
`default_nettype none

package issue_pkg;

    typedef logic [core_cfg_pkg::PRF_NUM_W-1:0] prf_num_t;

    // one alu op as held in the queue
    typedef struct packed {
        logic [core_cfg_pkg::TAG_W-1:0] tag;
        logic                           dst_en;
        prf_num_t                       dst;
        logic                           src_l_en;
        prf_num_t                       src_l;
        logic                           src_r_en;
        prf_num_t                       src_r;
    } alu_uop_t;

    // valid is a single-cycle strobe
    typedef struct packed {
        logic     valid;
        alu_uop_t uop;
    } dispatch_slot_t;

    typedef struct packed {
        logic     valid;
        alu_uop_t uop;
    } issue_slot_t;

    // writeback or issue wakeup
    typedef struct packed {
        logic     en;
        prf_num_t num;
    } prf_clear_t;

endpackage

`default_nettype wire

//--- source/busy_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module busy_scoreboard (
    input  wire                                                        clk,
    input  wire                                                        rst,
    input  wire                                                        flush_i,
    input  wire issue_pkg::dispatch_slot_t [core_cfg_pkg::DISPATCH_WIDTH-1:0] set_i,
    input  wire issue_pkg::prf_clear_t [core_cfg_pkg::CLEAR_PORTS-1:0] clear_i,
    input  wire issue_pkg::prf_num_t [core_cfg_pkg::IQ_DEPTH-1:0]      rd_num_l_i,
    input  wire issue_pkg::prf_num_t [core_cfg_pkg::IQ_DEPTH-1:0]      rd_num_r_i,
    output logic [core_cfg_pkg::IQ_DEPTH-1:0]                          busy_l_o,
    output logic [core_cfg_pkg::IQ_DEPTH-1:0]                          busy_r_o
);

    logic [core_cfg_pkg::PRF_COUNT-1:0] busy_q;
    logic [core_cfg_pkg::PRF_COUNT-1:0] busy_d;

    // clears first, then sets, so a fresh allocation wins
    always_comb begin
        busy_d = busy_q;
        for (int c = 0; c < core_cfg_pkg::CLEAR_PORTS; c++) begin
            if (clear_i[c].en) begin
                busy_d[clear_i[c].num] = 1'b0;
            end
        end
        for (int s = 0; s < core_cfg_pkg::DISPATCH_WIDTH; s++) begin
            if (set_i[s].valid && set_i[s].uop.dst_en) begin
                busy_d[set_i[s].uop.dst] = 1'b1;
            end
        end
    end

    // flush drops the dispatch of the same cycle
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_d;
        end
    end

    // per-entry lookup
    always_comb begin
        for (int e = 0; e < core_cfg_pkg::IQ_DEPTH; e++) begin
            busy_l_o[e] = busy_q[rd_num_l_i[e]];
            busy_r_o[e] = busy_q[rd_num_r_i[e]];
        end
    end

    // rename never hands out one register twice in a dispatch group
    assert property (@(posedge clk) disable iff (rst)
        (set_i[0].valid && set_i[0].uop.dst_en && set_i[1].valid && set_i[1].uop.dst_en)
        |-> (set_i[0].uop.dst != set_i[1].uop.dst))
        else $error("both dispatch slots set register %0d", set_i[0].uop.dst);

endmodule

`default_nettype wire

//--- source/issue_select.sv
`timescale 1ns/1ps
`default_nettype none

module issue_select (
    input  wire [core_cfg_pkg::IQ_DEPTH-1:0]                              ready_vec_i,
    output logic [core_cfg_pkg::ISSUE_WIDTH-1:0][core_cfg_pkg::IQ_IDX_W-1:0] grant_idx_o,
    output logic [core_cfg_pkg::ISSUE_WIDTH-1:0]                          grant_valid_o
);

    // lowest index is oldest since the queue collapses
    always_comb begin : pick
        logic [core_cfg_pkg::IQ_DEPTH-1:0] remaining;
        logic                              found;
        logic [core_cfg_pkg::IQ_IDX_W-1:0] idx;

        remaining = ready_vec_i;
        for (int g = 0; g < core_cfg_pkg::ISSUE_WIDTH; g++) begin
            found = 1'b0;
            idx   = '0;
            // scan down so the lowest ready index is kept
            for (int e = core_cfg_pkg::IQ_DEPTH - 1; e >= 0; e--) begin
                if (remaining[e]) begin
                    found = 1'b1;
                    idx   = e[core_cfg_pkg::IQ_IDX_W-1:0];
                end
            end
            grant_valid_o[g] = found;
            grant_idx_o[g]   = idx;
            // mask out so the next grant finds the following entry
            if (found) begin
                remaining[idx] = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/alu_issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module alu_issue_queue (
    input  wire                                                             clk,
    input  wire                                                             rst,
    input  wire                                                             flush_i,
    input  wire issue_pkg::dispatch_slot_t [core_cfg_pkg::DISPATCH_WIDTH-1:0] dispatch_i,
    input  wire [core_cfg_pkg::IQ_DEPTH-1:0]                                busy_l_i,
    input  wire [core_cfg_pkg::IQ_DEPTH-1:0]                                busy_r_i,
    output issue_pkg::prf_num_t [core_cfg_pkg::IQ_DEPTH-1:0]                rd_num_l_o,
    output issue_pkg::prf_num_t [core_cfg_pkg::IQ_DEPTH-1:0]                rd_num_r_o,
    output issue_pkg::issue_slot_t [core_cfg_pkg::ISSUE_WIDTH-1:0]          issue_o,
    output issue_pkg::prf_clear_t [core_cfg_pkg::ISSUE_WIDTH-1:0]           wakeup_o,
    output logic                                                            ready_o
);

    issue_pkg::alu_uop_t entry_q [core_cfg_pkg::IQ_DEPTH];
    issue_pkg::alu_uop_t entry_d [core_cfg_pkg::IQ_DEPTH];
    logic [core_cfg_pkg::IQ_CNT_W-1:0] count_q;
    logic [core_cfg_pkg::IQ_CNT_W-1:0] count_d;

    logic [core_cfg_pkg::IQ_DEPTH-1:0]                                 ready_vec;
    logic [core_cfg_pkg::IQ_DEPTH-1:0]                                 removed;
    logic [core_cfg_pkg::ISSUE_WIDTH-1:0][core_cfg_pkg::IQ_IDX_W-1:0]  grant_idx;
    logic [core_cfg_pkg::ISSUE_WIDTH-1:0]                              grant_valid;
    logic [core_cfg_pkg::DISPATCH_WIDTH-1:0]                           disp_valid;

    always_comb begin
        for (int s = 0; s < core_cfg_pkg::DISPATCH_WIDTH; s++) begin
            disp_valid[s] = dispatch_i[s].valid;
        end
    end

    // source lookup and readiness
    always_comb begin
        for (int e = 0; e < core_cfg_pkg::IQ_DEPTH; e++) begin
            rd_num_l_o[e] = entry_q[e].src_l;
            rd_num_r_o[e] = entry_q[e].src_r;
            ready_vec[e]  = (e < count_q)
                && !(entry_q[e].src_l_en && busy_l_i[e])
                && !(entry_q[e].src_r_en && busy_r_i[e]);
        end
    end

    issue_select u_select (
        .ready_vec_i   (ready_vec),
        .grant_idx_o   (grant_idx),
        .grant_valid_o (grant_valid)
    );

    // issue and wakeup in the same cycle
    always_comb begin
        removed = '0;
        for (int g = 0; g < core_cfg_pkg::ISSUE_WIDTH; g++) begin
            issue_o[g].valid = grant_valid[g];
            issue_o[g].uop   = entry_q[grant_idx[g]];
            wakeup_o[g].en   = grant_valid[g] && entry_q[grant_idx[g]].dst_en;
            wakeup_o[g].num  = entry_q[grant_idx[g]].dst;
            if (grant_valid[g]) begin
                removed[grant_idx[g]] = 1'b1;
            end
        end
    end

    // collapse survivors, then append dispatch in slot order
    always_comb begin : compact
        logic [core_cfg_pkg::IQ_CNT_W-1:0] wr;

        wr = '0;
        entry_d = entry_q;
        for (int e = 0; e < core_cfg_pkg::IQ_DEPTH; e++) begin
            if (e < count_q && !removed[e]) begin
                entry_d[wr[core_cfg_pkg::IQ_IDX_W-1:0]] = entry_q[e];
                wr = wr + 1'b1;
            end
        end
        for (int s = 0; s < core_cfg_pkg::DISPATCH_WIDTH; s++) begin
            if (disp_valid[s]) begin
                entry_d[wr[core_cfg_pkg::IQ_IDX_W-1:0]] = dispatch_i[s].uop;
                wr = wr + 1'b1;
            end
        end
        count_d = wr;
    end

    always_ff @(posedge clk) begin
        entry_q <= entry_d;
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

    // room for a full dispatch group
    assign ready_o = (count_q <= core_cfg_pkg::IQ_DEPTH - core_cfg_pkg::DISPATCH_WIDTH);

    assert property (@(posedge clk) disable iff (rst) !ready_o |-> (disp_valid == '0))
        else $error("dispatch while queue not ready");

    assert property (@(posedge clk) disable iff (rst) count_q <= core_cfg_pkg::IQ_DEPTH)
        else $error("queue occupancy %0d over depth", count_q);

endmodule

`default_nettype wire

//--- source/alu_issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_issue_top (
    input  wire                                                             clk,
    input  wire                                                             rst,
    input  wire                                                             flush_i,
    input  wire issue_pkg::dispatch_slot_t [core_cfg_pkg::DISPATCH_WIDTH-1:0] dispatch_i,
    input  wire issue_pkg::prf_clear_t [core_cfg_pkg::WB_PORTS-1:0]         wb_i,
    output logic                                                            ready_o,
    output issue_pkg::issue_slot_t [core_cfg_pkg::ISSUE_WIDTH-1:0]          issue_o
);

    issue_pkg::prf_num_t [core_cfg_pkg::IQ_DEPTH-1:0]     rd_num_l;
    issue_pkg::prf_num_t [core_cfg_pkg::IQ_DEPTH-1:0]     rd_num_r;
    logic [core_cfg_pkg::IQ_DEPTH-1:0]                    busy_l;
    logic [core_cfg_pkg::IQ_DEPTH-1:0]                    busy_r;
    issue_pkg::prf_clear_t [core_cfg_pkg::ISSUE_WIDTH-1:0] wakeup;
    issue_pkg::prf_clear_t [core_cfg_pkg::CLEAR_PORTS-1:0] clear_all;

    // wakeups on the low ports, writebacks above
    assign clear_all = {wb_i, wakeup};

    alu_issue_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (flush_i),
        .dispatch_i (dispatch_i),
        .busy_l_i   (busy_l),
        .busy_r_i   (busy_r),
        .rd_num_l_o (rd_num_l),
        .rd_num_r_o (rd_num_r),
        .issue_o    (issue_o),
        .wakeup_o   (wakeup),
        .ready_o    (ready_o)
    );

    busy_scoreboard u_scoreboard (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (flush_i),
        .set_i      (dispatch_i),
        .clear_i    (clear_all),
        .rd_num_l_i (rd_num_l),
        .rd_num_r_i (rd_num_r),
        .busy_l_o   (busy_l),
        .busy_r_o   (busy_r)
    );

endmodule

`default_nettype wire

//--- tests/issue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module issue_tb;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_PHASES = 3;
    localparam int PHASE_CYCLES = 300;
    localparam int WATCHDOG_MARGIN = 200;
    // registers used by stimulus, kept small so dependencies are frequent
    localparam int REG_POOL = 16;

    // per phase: steady mix, dense dispatch with rare writeback, flushes
    int disp_pct [NUM_PHASES] = '{45, 95, 60};
    int wb_pct [NUM_PHASES] = '{20, 3, 15};
    int flush_pct [NUM_PHASES] = '{0, 0, 4};

    logic clk;
    logic rst;
    logic flush;
    logic ready;
    issue_pkg::dispatch_slot_t [core_cfg_pkg::DISPATCH_WIDTH-1:0] dispatch;
    issue_pkg::prf_clear_t [core_cfg_pkg::WB_PORTS-1:0]           wb;
    issue_pkg::issue_slot_t [core_cfg_pkg::ISSUE_WIDTH-1:0]       issue;

    // reference state
    issue_pkg::alu_uop_t model_q [$];
    logic [core_cfg_pkg::PRF_COUNT-1:0] model_busy = '0;
    logic [core_cfg_pkg::PRF_COUNT-1:0] inflight = '0;
    issue_pkg::issue_slot_t [core_cfg_pkg::ISSUE_WIDTH-1:0] exp_issue;
    logic exp_ready;

    int errors = 0;
    int checks = 0;
    int issued = 0;
    int next_tag = 0;
    issue_pkg::prf_num_t last_dst = '0;

    alu_issue_top uut (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (flush),
        .dispatch_i (dispatch),
        .wb_i       (wb),
        .ready_o    (ready),
        .issue_o    (issue)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    // expected outputs of this cycle, then the state after the edge
    function automatic void model_step(input logic flush_in,
            input issue_pkg::dispatch_slot_t [core_cfg_pkg::DISPATCH_WIDTH-1:0] disp_in,
            input issue_pkg::prf_clear_t [core_cfg_pkg::WB_PORTS-1:0] wb_in);
        int picked [$];
        int n;
        logic src_ok;

        n = 0;
        exp_issue = '0;
        exp_ready = (model_q.size() <= core_cfg_pkg::IQ_DEPTH - core_cfg_pkg::DISPATCH_WIDTH);
        for (int i = 0; i < model_q.size(); i++) begin
            src_ok = (!model_q[i].src_l_en || !model_busy[model_q[i].src_l])
                && (!model_q[i].src_r_en || !model_busy[model_q[i].src_r]);
            if (src_ok && n < core_cfg_pkg::ISSUE_WIDTH) begin
                exp_issue[n].valid = 1'b1;
                exp_issue[n].uop = model_q[i];
                picked.push_back(i);
                n++;
            end
        end
        if (flush_in) begin
            model_q.delete();
            model_busy = '0;
            inflight = '0;
        end else begin
            // oldest index last so earlier positions stay valid
            for (int g = n - 1; g >= 0; g--) begin
                if (model_q[picked[g]].dst_en) begin
                    model_busy[model_q[picked[g]].dst] = 1'b0;
                    inflight[model_q[picked[g]].dst] = 1'b0;
                end
                model_q.delete(picked[g]);
            end
            for (int p = 0; p < core_cfg_pkg::WB_PORTS; p++) begin
                if (wb_in[p].en) model_busy[wb_in[p].num] = 1'b0;
            end
            for (int s = 0; s < core_cfg_pkg::DISPATCH_WIDTH; s++) begin
                if (disp_in[s].valid) begin
                    if (disp_in[s].uop.dst_en) model_busy[disp_in[s].uop.dst] = 1'b1;
                    model_q.push_back(disp_in[s].uop);
                end
            end
        end
    endfunction

    task automatic drive_random_inputs(input int phase);
        issue_pkg::dispatch_slot_t slot;
        int start;
        int r;

        flush = ($urandom_range(99) < flush_pct[phase]);
        for (int s = 0; s < core_cfg_pkg::DISPATCH_WIDTH; s++) begin
            slot = '0;
            if (model_q.size() <= core_cfg_pkg::IQ_DEPTH - core_cfg_pkg::DISPATCH_WIDTH
                    && $urandom_range(99) < disp_pct[phase]) begin
                slot.valid = 1'b1;
                slot.uop.tag = 8'(next_tag);
                next_tag++;
                // first free register from a random start
                start = $urandom_range(REG_POOL - 1);
                for (int k = 0; k < REG_POOL; k++) begin
                    r = (start + k) % REG_POOL;
                    if (!slot.uop.dst_en && !inflight[r]) begin
                        slot.uop.dst_en = ($urandom_range(7) != 0);
                        slot.uop.dst = 6'(r);
                    end
                end
                slot.uop.src_l_en = ($urandom_range(3) != 0);
                slot.uop.src_l = $urandom_range(1) ? last_dst : 6'($urandom_range(REG_POOL - 1));
                slot.uop.src_r_en = ($urandom_range(1) != 0);
                slot.uop.src_r = 6'($urandom_range(REG_POOL - 1));
                if (slot.uop.dst_en) begin
                    inflight[slot.uop.dst] = 1'b1;
                    last_dst = slot.uop.dst;
                end
            end
            dispatch[s] = slot;
        end
        for (int p = 0; p < core_cfg_pkg::WB_PORTS; p++) begin
            wb[p].en = ($urandom_range(99) < wb_pct[phase]);
            wb[p].num = 6'($urandom_range(REG_POOL - 1));
        end
    endtask

    always @(posedge clk) begin : compare
        if (!rst) begin
            model_step(flush, dispatch, wb);
            check_value("ready_o", 64'(ready), 64'(exp_ready));
            for (int g = 0; g < core_cfg_pkg::ISSUE_WIDTH; g++) begin
                check_value($sformatf("issue_o[%0d].valid", g),
                            64'(issue[g].valid), 64'(exp_issue[g].valid));
                if (exp_issue[g].valid) begin
                    check_value($sformatf("issue_o[%0d].uop", g),
                                64'(issue[g].uop), 64'(exp_issue[g].uop));
                    issued++;
                end
            end
        end
    end

    initial begin : stimulus
        void'($urandom(41839));
        rst = 1'b1;
        flush = 1'b0;
        dispatch = '0;
        wb = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        for (int p = 0; p < NUM_PHASES; p++) begin
            for (int c = 0; c < PHASE_CYCLES; c++) begin
                drive_random_inputs(p);
                @(negedge clk);
            end
        end
        flush = 1'b0;
        dispatch = '0;
        wb = '0;
        @(negedge clk);
        if (issued == 0) begin
            $display("no op was issued during the run");
            errors++;
        end
        $display("%0d checks, %0d ops issued, %0d errors", checks, issued, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #((RESET_CYCLES + NUM_PHASES * PHASE_CYCLES + WATCHDOG_MARGIN) * CLK_PERIOD);
        $display("timeout: the run did not reach its end in time");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
source/core_cfg_pkg.sv
source/issue_pkg.sv
source/busy_scoreboard.sv
source/issue_select.sv
source/alu_issue_queue.sv
source/alu_issue_top.sv
tests/issue_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ALU issue stage testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module issue_tb \
    --Mdir obj_dir \
    -o issue_sim \
    -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/issue_sim)"
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    exit 0
else
    echo "simulation reported failures"
    exit 1
fi
